//--- logic/ov_cfg_pkg.sv
// Shared types for the OV5640 configuration path; the command index is sized to hold REG_NUM itself
`default_nettype none

package ov_cfg_pkg;

    // ************************************************************
    // Table geometry
    // ************************************************************
    localparam int REG_NUM      = 64;   // Entries in the command table
    localparam int NUM_ID_READS = 2;    // Leading chip ID reads
    localparam int IDX_W        = $clog2(REG_NUM + 1);

    typedef logic [IDX_W-1:0] reg_idx_t;    // Reaches REG_NUM after the last exec
    typedef logic [12:0]      dim_t;        // Frame dimension in pixels or lines
    typedef logic [15:0]      reg_addr_t;   // SCCB register address
    typedef logic [7:0]       reg_val_t;    // SCCB register value

    // Address in [23:8], value in [7:0]
    typedef logic [23:0]      cmd_word_t;

    // ************************************************************
    // Encodings
    // ************************************************************
    typedef enum logic [1:0] {
        ST_POWERUP,     // Sensor power-up wait
        ST_ISSUE,       // Exec strobe is high
        ST_WAIT_DONE,   // Command outstanding at the I2C master
        ST_DONE         // Table finished
    } cfg_state_e;

    // Source of the data byte of one table entry
    typedef enum logic [3:0] {
        FLD_FIXED,      // Constant from the table
        FLD_H_ACT_HI,   // {4'd0, cmos_h_pixel[11:8]}
        FLD_H_ACT_LO,   // cmos_h_pixel[7:0]
        FLD_V_ACT_HI,   // {5'd0, cmos_v_pixel[10:8]}
        FLD_V_ACT_LO,   // cmos_v_pixel[7:0]
        FLD_H_TOT_HI,   // {3'd0, total_h_pixel[12:8]}
        FLD_H_TOT_LO,   // total_h_pixel[7:0]
        FLD_V_TOT_HI,   // {3'd0, total_v_pixel[12:8]}
        FLD_V_TOT_LO    // total_v_pixel[7:0]
    } field_sel_e;

endpackage

`default_nettype wire

//--- logic/ov_cfg_table.sv
// Geometry inputs are sampled as their entry loads and must stay stable until init_done
`timescale 1ns/1ps
`default_nettype none

module ov_cfg_table (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ov_cfg_pkg::reg_idx_t  index,
    input  ov_cfg_pkg::dim_t      cmos_h_pixel,     // Active width
    input  ov_cfg_pkg::dim_t      cmos_v_pixel,     // Active height
    input  ov_cfg_pkg::dim_t      total_h_pixel,    // Total width incl. blanking
    input  ov_cfg_pkg::dim_t      total_v_pixel,    // Total height incl. blanking
    output ov_cfg_pkg::cmd_word_t cmd_data
);
    import ov_cfg_pkg::*;

    reg_addr_t  entry_addr;
    reg_val_t   entry_val;
    field_sel_e entry_fld;
    reg_val_t   data_byte;

    // ************************************************************
    // Register table
    // ************************************************************
    always_comb begin
        entry_addr = '0;
        entry_val  = '0;
        entry_fld  = FLD_FIXED;
        case (index)
            // Chip ID, read back by the master
            7'd0  : {entry_addr, entry_val} = {16'h300a, 8'h00};
            7'd1  : {entry_addr, entry_val} = {16'h300b, 8'h00};
            // Soft reset, then power back on
            7'd2  : {entry_addr, entry_val} = {16'h3008, 8'h82};
            7'd3  : {entry_addr, entry_val} = {16'h3008, 8'h02};
            7'd4  : {entry_addr, entry_val} = {16'h3103, 8'h02};   // System clock from PLL
            7'd5  : {entry_addr, entry_val} = {16'h3017, 8'hff};   // Pad output enables
            7'd6  : {entry_addr, entry_val} = {16'h3018, 8'hff};
            7'd7  : {entry_addr, entry_val} = {16'h3037, 8'h13};   // PLL root divider
            7'd8  : {entry_addr, entry_val} = {16'h3108, 8'h01};
            7'd9  : {entry_addr, entry_val} = {16'h3035, 8'h21};   // Sys clock divider
            7'd10 : {entry_addr, entry_val} = {16'h3036, 8'h69};   // PLL multiplier
            // Analog and core setup
            7'd11 : {entry_addr, entry_val} = {16'h3630, 8'h36};
            7'd12 : {entry_addr, entry_val} = {16'h3631, 8'h0e};
            7'd13 : {entry_addr, entry_val} = {16'h3632, 8'he2};
            7'd14 : {entry_addr, entry_val} = {16'h3633, 8'h12};
            7'd15 : {entry_addr, entry_val} = {16'h3621, 8'he0};
            7'd16 : {entry_addr, entry_val} = {16'h3704, 8'ha0};
            7'd17 : {entry_addr, entry_val} = {16'h3703, 8'h5a};
            7'd18 : {entry_addr, entry_val} = {16'h3715, 8'h78};
            7'd19 : {entry_addr, entry_val} = {16'h3717, 8'h01};
            7'd20 : {entry_addr, entry_val} = {16'h370b, 8'h60};
            7'd21 : {entry_addr, entry_val} = {16'h3705, 8'h1a};
            7'd22 : {entry_addr, entry_val} = {16'h3905, 8'h02};
            7'd23 : {entry_addr, entry_val} = {16'h3906, 8'h10};
            7'd24 : {entry_addr, entry_val} = {16'h3901, 8'h0a};
            7'd25 : {entry_addr, entry_val} = {16'h3731, 8'h12};
            7'd26 : {entry_addr, entry_val} = {16'h302d, 8'h60};
            7'd27 : {entry_addr, entry_val} = {16'h3620, 8'h52};
            7'd28 : {entry_addr, entry_val} = {16'h371b, 8'h20};
            7'd29 : {entry_addr, entry_val} = {16'h471c, 8'h50};
            // AEC window and limits
            7'd30 : {entry_addr, entry_val} = {16'h3a13, 8'h43};
            7'd31 : {entry_addr, entry_val} = {16'h3a18, 8'h00};   // Gain ceiling
            7'd32 : {entry_addr, entry_val} = {16'h3a19, 8'hf8};
            7'd33 : {entry_addr, entry_val} = {16'h3a0f, 8'h30};   // Stable range in
            7'd34 : {entry_addr, entry_val} = {16'h3a10, 8'h28};
            7'd35 : {entry_addr, entry_val} = {16'h3a1b, 8'h30};   // Stable range out
            7'd36 : {entry_addr, entry_val} = {16'h3a1e, 8'h26};
            7'd37 : {entry_addr, entry_val} = {16'h3a11, 8'h60};   // Fast zone
            7'd38 : {entry_addr, entry_val} = {16'h3a1f, 8'h14};
            // Output format
            7'd39 : {entry_addr, entry_val} = {16'h4300, 8'h61};   // RGB565
            7'd40 : {entry_addr, entry_val} = {16'h501f, 8'h01};   // ISP RGB path
            7'd41 : {entry_addr, entry_val} = {16'h5000, 8'ha7};   // ISP enables
            // Timing window
            7'd42 : {entry_addr, entry_val} = {16'h3820, 8'h46};
            7'd43 : {entry_addr, entry_val} = {16'h3821, 8'h01};
            7'd44 : {entry_addr, entry_val} = {16'h3814, 8'h31};   // Subsample steps
            7'd45 : {entry_addr, entry_val} = {16'h3815, 8'h31};
            7'd46 : {entry_addr, entry_val} = {16'h3806, 8'h06};   // Window end Y
            7'd47 : {entry_addr, entry_val} = {16'h3807, 8'ha9};
            // DVP output size and total size come from the live ports
            7'd48 : begin
                {entry_addr, entry_val} = {16'h3808, 8'h00};
                entry_fld = FLD_H_ACT_HI;
            end
            7'd49 : begin
                {entry_addr, entry_val} = {16'h3809, 8'h00};
                entry_fld = FLD_H_ACT_LO;
            end
            7'd50 : begin
                {entry_addr, entry_val} = {16'h380a, 8'h00};
                entry_fld = FLD_V_ACT_HI;
            end
            7'd51 : begin
                {entry_addr, entry_val} = {16'h380b, 8'h00};
                entry_fld = FLD_V_ACT_LO;
            end
            7'd52 : begin
                {entry_addr, entry_val} = {16'h380c, 8'h00};
                entry_fld = FLD_H_TOT_HI;
            end
            7'd53 : begin
                {entry_addr, entry_val} = {16'h380d, 8'h00};
                entry_fld = FLD_H_TOT_LO;
            end
            7'd54 : begin
                {entry_addr, entry_val} = {16'h380e, 8'h00};
                entry_fld = FLD_V_TOT_HI;
            end
            7'd55 : begin
                {entry_addr, entry_val} = {16'h380f, 8'h00};
                entry_fld = FLD_V_TOT_LO;
            end
            7'd56 : {entry_addr, entry_val} = {16'h3813, 8'h04};   // Y offset
            7'd57 : {entry_addr, entry_val} = {16'h4837, 8'h22};   // DVP PCLK divider
            7'd58 : {entry_addr, entry_val} = {16'h3824, 8'h04};
            7'd59 : {entry_addr, entry_val} = {16'h503d, 8'h00};   // Test pattern off
            // Strobe pad, pulse then release
            7'd60 : {entry_addr, entry_val} = {16'h3016, 8'h02};
            7'd61 : {entry_addr, entry_val} = {16'h301c, 8'h02};
            7'd62 : {entry_addr, entry_val} = {16'h3019, 8'h02};
            7'd63 : {entry_addr, entry_val} = {16'h3019, 8'h00};
            default : ;     // Index REG_NUM after the last exec, output is never issued
        endcase
    end

    // Geometry slices, high parts zero padded
    always_comb begin
        case (entry_fld)
            FLD_H_ACT_HI : data_byte = {4'd0, cmos_h_pixel[11:8]};
            FLD_H_ACT_LO : data_byte = cmos_h_pixel[7:0];
            FLD_V_ACT_HI : data_byte = {5'd0, cmos_v_pixel[10:8]};
            FLD_V_ACT_LO : data_byte = cmos_v_pixel[7:0];
            FLD_H_TOT_HI : data_byte = {3'd0, total_h_pixel[12:8]};
            FLD_H_TOT_LO : data_byte = total_h_pixel[7:0];
            FLD_V_TOT_HI : data_byte = {3'd0, total_v_pixel[12:8]};
            FLD_V_TOT_LO : data_byte = total_v_pixel[7:0];
            default      : data_byte = entry_val;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_data <= '0;
        end else begin
            cmd_data <= {entry_addr, data_byte};    // Valid one cycle after index
        end
    end

    // Live fields only ever feed the DVP size registers
    a_fld_addr : assert property (@(posedge clk) disable iff (!rst_n)
        (entry_fld != FLD_FIXED) |-> (entry_addr inside {[16'h3808 : 16'h380f]}));

endmodule

`default_nettype wire

//--- logic/ov_cfg_sequencer.sv
// No timeout on the I2C done pulse and POWERUP_CYCLES must be at least 1
`timescale 1ns/1ps
`default_nettype none

module ov_cfg_sequencer #(
    parameter int POWERUP_CYCLES = 5000     // 5 ms at 1 MHz
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_done,   // One-cycle completion from the master
    output ov_cfg_pkg::reg_idx_t index,
    output logic                 cmd_exec,
    output logic                 cmd_rd,     // 1 for the ID reads
    output logic                 init_done
);
    import ov_cfg_pkg::*;

    localparam int              PU_W     = $clog2(POWERUP_CYCLES + 1);
    localparam logic [PU_W-1:0] PU_LAST  = PU_W'(POWERUP_CYCLES - 1);
    localparam reg_idx_t        LAST_IDX = reg_idx_t'(REG_NUM);

    cfg_state_e      state;
    logic [PU_W-1:0] pu_cnt;

    // ************************************************************
    // Command FSM
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_POWERUP;
            pu_cnt    <= '0;
            index     <= '0;
            cmd_exec  <= 1'b0;
            init_done <= 1'b0;
        end else begin
            cmd_exec <= 1'b0;   // Strobe by default
            case (state)
                ST_POWERUP: begin
                    // First exec rises on the POWERUP_CYCLES-th edge
                    if (pu_cnt == PU_LAST) begin
                        cmd_exec <= 1'b1;
                        state    <= ST_ISSUE;
                    end else begin
                        pu_cnt <= pu_cnt + 1'b1;
                    end
                end
                ST_ISSUE: begin
                    // Master has captured the word, move on to the next entry
                    index <= index + 1'b1;
                    state <= ST_WAIT_DONE;
                end
                ST_WAIT_DONE: begin
                    if (cmd_done) begin
                        if (index == LAST_IDX) begin
                            init_done <= 1'b1;
                            state     <= ST_DONE;
                        end else begin
                            cmd_exec <= 1'b1;
                            state    <= ST_ISSUE;
                        end
                    end
                end
                ST_DONE: begin
                    init_done <= 1'b1;  // Stray done pulses are ignored here
                end
                default: begin
                    state <= ST_POWERUP;
                end
            endcase
        end
    end

    // Direction follows the index, settled well before each exec
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_rd <= 1'b1;
        end else begin
            cmd_rd <= (index < NUM_ID_READS);
        end
    end

    // ************************************************************
    // Checks
    // ************************************************************
    a_exec_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        cmd_exec |=> !cmd_exec);

    a_index_range : assert property (@(posedge clk) disable iff (!rst_n)
        index <= LAST_IDX);

    // Completion is sticky until the next reset
    a_done_sticky : assert property (@(posedge clk) disable iff (!rst_n)
        init_done |=> init_done);

endmodule

`default_nettype wire

//--- logic/ov5640_cfg_top.sv
// OV5640 power-up register loader for an external I2C master; geometry inputs must hold until init_done
`timescale 1ns/1ps
`default_nettype none

module ov5640_cfg_top #(
    parameter int POWERUP_CYCLES = 5000     // Sensor power-up wait in clk cycles
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ov_cfg_pkg::dim_t      cmos_h_pixel,
    input  ov_cfg_pkg::dim_t      cmos_v_pixel,
    input  ov_cfg_pkg::dim_t      total_h_pixel,
    input  ov_cfg_pkg::dim_t      total_v_pixel,
    input  logic                  i2c_done,
    output logic                  i2c_exec,
    output ov_cfg_pkg::cmd_word_t i2c_data,     // {addr[15:0], value[7:0]}
    output logic                  i2c_rh_wl,    // 1 read, 0 write
    output logic                  init_done
);
    import ov_cfg_pkg::*;

    reg_idx_t cmd_index;    // Sequencer to table

    // ************************************************************
    // Sequencer and register table
    // ************************************************************
    ov_cfg_sequencer #(
        .POWERUP_CYCLES (POWERUP_CYCLES)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_done  (i2c_done),
        .index     (cmd_index),
        .cmd_exec  (i2c_exec),
        .cmd_rd    (i2c_rh_wl),
        .init_done (init_done)
    );

    // Registered word, stable by the time of each exec
    ov_cfg_table u_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .index         (cmd_index),
        .cmos_h_pixel  (cmos_h_pixel),
        .cmos_v_pixel  (cmos_v_pixel),
        .total_h_pixel (total_h_pixel),
        .total_v_pixel (total_v_pixel),
        .cmd_data      (i2c_data)
    );

endmodule

`default_nettype wire

//--- sim/tb_ov5640_cfg.sv
// Needs a timing-capable simulator run from the project root, which holds sim/ov_cfg_stim.txt
`timescale 1ns/1ps
`default_nettype none

module tb_ov5640_cfg;
    import ov_cfg_pkg::*;

    localparam int PU_CYCLES    = 40;
    localparam int CLK_HALF     = 4;        // 8 ns period
    localparam int RST_CYCLES   = 16;
    localparam int EXEC_TIMEOUT = 200;      // Cycles allowed for the first exec
    localparam int STIM_WORDS   = 8 + 2 * REG_NUM;

    logic      clk;
    logic      rst_n;
    dim_t      cmos_h_pixel;
    dim_t      cmos_v_pixel;
    dim_t      total_h_pixel;
    dim_t      total_v_pixel;
    logic      i2c_done;
    logic      i2c_exec;
    cmd_word_t i2c_data;
    logic      i2c_rh_wl;
    logic      init_done;

    logic [23:0] stim_mem [0:STIM_WORDS-1];    // Geometry words, then word/direction pairs
    cmd_word_t   exp_cmd  [0:REG_NUM-1];
    logic        exp_rd   [0:REG_NUM-1];
    logic [31:0] lfsr_state;

    ov5640_cfg_top #(
        .POWERUP_CYCLES (PU_CYCLES)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmos_h_pixel  (cmos_h_pixel),
        .cmos_v_pixel  (cmos_v_pixel),
        .total_h_pixel (total_h_pixel),
        .total_v_pixel (total_v_pixel),
        .i2c_done      (i2c_done),
        .i2c_exec      (i2c_exec),
        .i2c_data      (i2c_data),
        .i2c_rh_wl     (i2c_rh_wl),
        .init_done     (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ************************************************************
    // Helpers
    // ************************************************************
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("ERR %s expected 0x%0h actual 0x%0h", name, exp, act));
        end
    endtask

    // Drive and sample point, 1 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int nbits, output int val);
        int b;
        val = 0;
        for (b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Data byte of a size register, from the raw stim dimensions
    function automatic reg_val_t geom_byte(input int entry, input int set);
        logic [31:0] h_act;
        logic [31:0] v_act;
        logic [31:0] h_tot;
        logic [31:0] v_tot;
        h_act = 32'(stim_mem[set*4 + 0][12:0]);
        v_act = 32'(stim_mem[set*4 + 1][12:0]);
        h_tot = 32'(stim_mem[set*4 + 2][12:0]);
        v_tot = 32'(stim_mem[set*4 + 3][12:0]);
        case (entry)
            48: return 8'((h_act >> 8) & 32'h0f);  // Only 12 bits of active width
            49: return 8'(h_act & 32'hff);
            50: return 8'((v_act >> 8) & 32'h07);
            51: return 8'(v_act & 32'hff);
            52: return 8'((h_tot >> 8) & 32'h1f);
            53: return 8'(h_tot & 32'hff);
            54: return 8'((v_tot >> 8) & 32'h1f);
            55: return 8'(v_tot & 32'hff);
            default: return 8'h00;
        endcase
    endfunction

    task automatic load_expected(input int set);
        int i;
        for (i = 0; i < REG_NUM; i++) begin
            exp_cmd[i] = stim_mem[8 + 2*i];
            exp_rd[i]  = stim_mem[9 + 2*i][0];
        end
        if (set != 0) begin
            // Stim lines hold set one, size registers recomputed for the rest
            for (i = 48; i < 56; i++) begin
                exp_cmd[i] = {16'h3808 + 16'(i - 48), geom_byte(i, set)};
            end
        end
    endtask

    // ************************************************************
    // Sequence phases
    // ************************************************************
    task automatic apply_reset(input int set);
        int k;
        rst_n         = 1'b0;
        i2c_done      = 1'b0;
        cmos_h_pixel  = stim_mem[set*4 + 0][12:0];
        cmos_v_pixel  = stim_mem[set*4 + 1][12:0];
        total_h_pixel = stim_mem[set*4 + 2][12:0];
        total_v_pixel = stim_mem[set*4 + 3][12:0];
        for (k = 0; k < RST_CYCLES; k++) begin
            next_cycle();
            check_value("reset exec", 32'd0, 32'(i2c_exec));
            check_value("reset init_done", 32'd0, 32'(init_done));
            check_value("reset rh_wl", 32'd1, 32'(i2c_rh_wl));
            check_value("reset data", 32'd0, 32'(i2c_data));
        end
        rst_n = 1'b1;
    endtask

    task automatic check_powerup();
        int   cyc;
        logic found;
        cyc   = 0;
        found = 1'b0;
        while (!found && cyc < EXEC_TIMEOUT) begin
            next_cycle();
            cyc++;
            if (i2c_exec) begin
                found = 1'b1;
            end else begin
                check_value("powerup init_done", 32'd0, 32'(init_done));
                check_value("powerup rh_wl", 32'd1, 32'(i2c_rh_wl));
            end
        end
        if (!found) begin
            abort_run($sformatf("no exec within %0d cycles after reset release", EXEC_TIMEOUT));
        end
        check_value("first exec cycle", 32'(PU_CYCLES), 32'(cyc));
    endtask

    // Master model, exec is high at the sample point on entry
    task automatic run_commands(input int set, input int delay_scale);
        int i;
        int c;
        int delay;
        for (i = 0; i < REG_NUM; i++) begin
            check_value($sformatf("set%0d cmd%0d word", set, i), 32'(exp_cmd[i]), 32'(i2c_data));
            check_value($sformatf("set%0d cmd%0d rh_wl", set, i), 32'(exp_rd[i]),
                        32'(i2c_rh_wl));
            draw_bits(4, delay);
            delay = delay * delay_scale;
            for (c = 0; c <= delay; c++) begin
                next_cycle();
                check_value("exec while outstanding", 32'd0, 32'(i2c_exec));
                check_value("init_done while outstanding", 32'd0, 32'(init_done));
            end
            i2c_done = 1'b1;
            next_cycle();
            i2c_done = 1'b0;
            if (i < REG_NUM - 1) begin
                check_value("exec one cycle after done", 32'd1, 32'(i2c_exec));
                check_value("init_done before last done", 32'd0, 32'(init_done));
            end else begin
                check_value("init_done after last done", 32'd1, 32'(init_done));
                check_value("exec after last done", 32'd0, 32'(i2c_exec));
            end
        end
    endtask

    // Stray done pulses once the table is finished
    task automatic check_after_done();
        int k;
        for (k = 0; k < 4; k++) begin
            i2c_done = 1'b1;
            next_cycle();
            i2c_done = 1'b0;
            check_value("exec after completion", 32'd0, 32'(i2c_exec));
            check_value("init_done held", 32'd1, 32'(init_done));
            next_cycle();
            check_value("exec after stray done", 32'd0, 32'(i2c_exec));
            check_value("init_done held", 32'd1, 32'(init_done));
        end
    endtask

    // ************************************************************
    // Main sequence
    // ************************************************************
    initial begin
        rst_n         = 1'b0;
        i2c_done      = 1'b0;
        cmos_h_pixel  = '0;
        cmos_v_pixel  = '0;
        total_h_pixel = '0;
        total_v_pixel = '0;
        lfsr_state    = 32'h1a7a_37be;

        $readmemh("sim/ov_cfg_stim.txt", stim_mem);
        if (stim_mem[9] !== 24'h1) begin    // Entry 0 must be a read
            abort_run("stim file sim/ov_cfg_stim.txt is missing or malformed");
        end

        apply_reset(0);
        check_powerup();
        load_expected(0);
        run_commands(0, 1);
        check_after_done();

        // Fresh reset, second geometry and longer master delays
        apply_reset(1);
        check_powerup();
        load_expected(1);
        run_commands(1, 4);
        check_after_done();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/ov_cfg_pkg.sv
logic/ov_cfg_table.sv
logic/ov_cfg_sequencer.sv
logic/ov5640_cfg_top.sv
sim/tb_ov5640_cfg.sv

//--- run.sh
#!/bin/sh
# Build and run the OV5640 config testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ov5640_cfg \
    -f filelist.f \
    -o tb_ov5640_cfg

./obj_dir/tb_ov5640_cfg | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: simulation failed"
    exit 1
fi

//--- sim/ov_cfg_stim.txt
// Lines 1-2: geometry sets, columns cmos_h cmos_v total_h total_v (hex)
// Lines 3-66: entries 0-63 for set one, columns {addr, value} rh_wl (1 = read)
0280 01e0 0764 02e4
1abc 1f5a 1c37 0e91
300a00 1
300b00 1
300882 0
300802 0
310302 0
3017ff 0
3018ff 0
303713 0
310801 0
303521 0
303669 0
363036 0
36310e 0
3632e2 0
363312 0
3621e0 0
3704a0 0
37035a 0
371578 0
371701 0
370b60 0
37051a 0
390502 0
390610 0
39010a 0
373112 0
302d60 0
362052 0
371b20 0
471c50 0
3a1343 0
3a1800 0
3a19f8 0
3a0f30 0
3a1028 0
3a1b30 0
3a1e26 0
3a1160 0
3a1f14 0
430061 0
501f01 0
5000a7 0
382046 0
382101 0
381431 0
381531 0
380606 0
3807a9 0
380802 0
380980 0
380a01 0
380be0 0
380c07 0
380d64 0
380e02 0
380fe4 0
381304 0
483722 0
382404 0
503d00 0
301602 0
301c02 0
301902 0
301900 0
